//--- Makefile
TOP := pcie_phy_tx_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- build.f
hw/pcie_phy_pkg.sv
hw/lane_stream_pkg.sv
hw/beat_fifo.sv
hw/sync_header_gen.sv
hw/lane_management.sv
hw/pcie_phy_tx_top.sv
tb/pcie_phy_tx_asserts.sv
tb/pcie_phy_tx_tb.sv

//--- hw/beat_fifo.sv
`timescale 1ns/100ps

module beat_fifo #(
  parameter type beat_t     = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  beat_t wr_beat_i,
  input  logic  wr_valid_i,
  output logic  wr_ready_o,
  output beat_t rd_beat_o,
  output logic  rd_valid_o,
  input  logic  rd_ready_i
);

  localparam int PtrW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CntW = $clog2(FIFO_DEPTH + 1);

  beat_t           mem_r [FIFO_DEPTH];
  logic [PtrW-1:0] wr_ptr_r;
  logic [PtrW-1:0] rd_ptr_r;
  logic [CntW-1:0] count_r;
  logic [CntW-1:0] count_c;
  logic            wr_ready_r;
  logic            wr_fire_c;
  logic            rd_fire_c;

  assign wr_fire_c  = wr_valid_i & wr_ready_r;
  assign rd_fire_c  = rd_valid_o & rd_ready_i;
  assign wr_ready_o = wr_ready_r;
  assign rd_valid_o = (count_r != '0);
  assign rd_beat_o  = mem_r[rd_ptr_r];

  always_comb begin
    count_c = count_r;
    if (wr_fire_c && !rd_fire_c) begin
      count_c = count_r + 1'b1;
    end else if (!wr_fire_c && rd_fire_c) begin
      count_c = count_r - 1'b1;
    end
  end

  // ready is a registered not-full flag, low while in reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
      wr_ready_r <= 1'b0;
    end else begin
      if (wr_fire_c) begin
        wr_ptr_r <= (wr_ptr_r == PtrW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_fire_c) begin
        rd_ptr_r <= (rd_ptr_r == PtrW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r    <= count_c;
      wr_ready_r <= (count_c != CntW'(FIFO_DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire_c) begin
      mem_r[wr_ptr_r] <= wr_beat_i;
    end
  end

endmodule

//--- hw/lane_management.sv
`timescale 1ns/100ps

module lane_management
  import pcie_phy_pkg::*, lane_stream_pkg::*;
#(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  stream_beat_t                           dllp_beat_i,
  input  logic                                   dllp_valid_i,
  output logic                                   dllp_ready_o,
  input  stream_beat_t                           os_beat_i,
  input  logic                                   os_valid_i,
  output logic                                   os_ready_o,
  input  rate_speed_e                            rate_i,
  input  logic [$clog2(MAX_NUM_LANES + 1)-1:0]   num_active_lanes_i,
  input  logic                                   lane_reverse_i,
  output pipe_lane_t                             lane_word_o [MAX_NUM_LANES],
  output logic [MAX_NUM_LANES-1:0]               lane_valid_o,
  output logic [5:0]                             pipe_width_o,
  output logic                                   block_start_o,
  output logic                                   is_os_o
);

  localparam int LaneCntW = $clog2(MAX_NUM_LANES + 1);
  localparam int BufBytes = MAX_BLOCK_BEATS * 4;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COLLECT_OS,
    ST_COLLECT_PKT,
    ST_TX_OS,
    ST_TX_PKT
  } lane_state_e;

  lane_state_e         state_r;
  rate_speed_e         rate_r;
  logic [LaneCntW-1:0] lanes_r;
  logic [5:0]          pipe_width_r;
  logic [4:0]          beat_cnt_r;
  logic [6:0]          consumed_r;
  logic                last_r;
  logic                mark_r;

  logic [BufBytes*8-1:0] buf_data_r;
  logic [BufBytes-1:0]   buf_k_r;

  stream_beat_t in_beat_c;
  logic         in_fire_c;
  logic         tx_state_c;
  logic         tx_os_c;
  logic [2:0]   wbytes_c;
  logic [7:0]   step_c;
  logic [6:0]   total_c;
  logic         tx_done_c;
  logic [7:0]   pad_c;

  assign os_ready_o   = (state_r == ST_COLLECT_OS);
  assign dllp_ready_o = (state_r == ST_COLLECT_PKT);
  assign in_beat_c    = (state_r == ST_COLLECT_OS) ? os_beat_i : dllp_beat_i;
  assign in_fire_c    = (os_valid_i & os_ready_o) | (dllp_valid_i & dllp_ready_o);

  assign tx_os_c    = (state_r == ST_TX_OS);
  assign tx_state_c = tx_os_c || (state_r == ST_TX_PKT);
  assign wbytes_c   = 3'(pipe_width_r >> 3);
  assign pad_c      = (rate_r >= gen3) ? PAD_SYMBOL : 8'h00;

  // ordered sets advance one word per cycle, packets one word on every lane
  assign step_c    = tx_os_c ? 8'(wbytes_c) : 8'(lanes_r) * 8'(wbytes_c);
  assign total_c   = {beat_cnt_r, 2'b00};
  assign tx_done_c = (8'(consumed_r) + step_c) >= 8'(total_c);

  assign pipe_width_o  = pipe_width_r;
  assign block_start_o = tx_state_c && (consumed_r == '0);
  assign is_os_o       = tx_os_c;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r      <= ST_IDLE;
      rate_r       <= gen1;
      lanes_r      <= LaneCntW'(1);
      pipe_width_r <= 6'd8;
      beat_cnt_r   <= '0;
      consumed_r   <= '0;
      last_r       <= 1'b0;
      mark_r       <= 1'b0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          rate_r       <= rate_i;
          lanes_r      <= num_active_lanes_i;
          pipe_width_r <= 6'(pipe_width_bits[rate_i]);
          beat_cnt_r   <= '0;
          consumed_r   <= '0;
          last_r       <= 1'b0;
          mark_r       <= 1'b0;
          // ordered sets win over packets
          if (os_valid_i) begin
            state_r <= ST_COLLECT_OS;
          end else if (dllp_valid_i) begin
            state_r <= ST_COLLECT_PKT;
          end
        end
        ST_COLLECT_OS, ST_COLLECT_PKT: begin
          if (in_fire_c) begin
            beat_cnt_r <= beat_cnt_r + 1'b1;
            mark_r     <= mark_r | in_beat_c.lane_num_mark;
            if (in_beat_c.last || (beat_cnt_r == 5'(MAX_BLOCK_BEATS - 1))) begin
              last_r  <= in_beat_c.last;
              state_r <= (state_r == ST_COLLECT_OS) ? ST_TX_OS : ST_TX_PKT;
            end
          end
        end
        ST_TX_OS, ST_TX_PKT: begin
          consumed_r <= consumed_r + 7'(step_c);
          if (tx_done_c) begin
            beat_cnt_r <= '0;
            consumed_r <= '0;
            mark_r     <= 1'b0;
            if (last_r) begin
              state_r <= ST_IDLE;
            end else begin
              // buffer full without last, keep going with the same source
              state_r <= tx_os_c ? ST_COLLECT_OS : ST_COLLECT_PKT;
            end
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
    end
  end

  // block buffer, byte 0 is always the next byte to send
  always_ff @(posedge clk_i) begin
    if (in_fire_c) begin
      for (int i = 0; i < 4; i++) begin
        buf_data_r[32*beat_cnt_r[3:0] + 8*i +: 8] <=
            in_beat_c.keep[i] ? in_beat_c.data[8*i +: 8] : pad_c;
        buf_k_r[4*beat_cnt_r[3:0] + i] <= in_beat_c.keep[i] & in_beat_c.kchar[i];
      end
    end else if (tx_state_c) begin
      buf_data_r <= buf_data_r >> {step_c, 3'b000};
      buf_k_r    <= buf_k_r >> step_c;
    end
  end

  always_comb begin : lane_map
    pipe_lane_t word;
    int         idx;
    logic [7:0] lane_num;
    lane_valid_o = '0;
    for (int l = 0; l < MAX_NUM_LANES; l++) begin
      word     = '0;
      idx      = 0;
      lane_num = lane_reverse_i ? 8'(lanes_r - LaneCntW'(1) - LaneCntW'(l)) : 8'(l);
      if (tx_state_c && (l < int'(lanes_r))) begin
        lane_valid_o[l] = 1'b1;
        for (int b = 0; b < 4; b++) begin
          if (b < int'(wbytes_c)) begin
            // packets stripe lane-first, ordered sets repeat on each lane
            idx = tx_os_c ? b : l + int'(lanes_r) * b;
            if (int'(consumed_r) + idx < int'(total_c)) begin
              word.data[8*b +: 8] = buf_data_r[8*idx +: 8];
              word.datak[b]       = buf_k_r[idx];
            end else begin
              word.data[8*b +: 8] = pad_c;
            end
            // lane number is a data symbol
            if (tx_os_c && mark_r && (int'(consumed_r) + b == 2)) begin
              word.data[8*b +: 8] = lane_num;
              word.datak[b]       = 1'b0;
            end
          end
        end
      end
      lane_word_o[l] = word;
    end
  end

endmodule

//--- hw/lane_stream_pkg.sv
package lane_stream_pkg;

  // one input beat, packet or ordered set
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    // control symbol flags, one per byte
    logic [3:0]  kchar;
    logic        last;
    // ordered sets only, byte 2 carries the lane number
    logic        lane_num_mark;
  } stream_beat_t;

  // one PIPE lane word, low bytes used first
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  datak;
  } pipe_lane_t;

endpackage

//--- hw/pcie_phy_pkg.sv
package pcie_phy_pkg;

  // link speed, only sampled while lane management is idle
  typedef enum logic [2:0] {
    gen1 = 3'd0,
    gen2 = 3'd1,
    gen3 = 3'd2,
    gen4 = 3'd3,
    gen5 = 3'd4
  } rate_speed_e;

  // PIPE data width in bits, indexed by rate_speed_e
  localparam int pipe_width_bits [5] = '{8, 16, 16, 32, 32};

  // filler for unused symbols in 128b/130b blocks
  localparam logic [7:0] PAD_SYMBOL = 8'hF7;

  // 128b/130b sync headers
  localparam logic [1:0] SYNC_DATA = 2'b10;
  localparam logic [1:0] SYNC_OS = 2'b01;

  // symbols per lane in one 128b/130b block
  localparam int BLOCK_SYMBOLS = 16;

  // 32-bit beats held by the 512-bit block buffer
  localparam int MAX_BLOCK_BEATS = 16;

endpackage

//--- hw/pcie_phy_tx_top.sv
`timescale 1ns/100ps

module pcie_phy_tx_top
  import pcie_phy_pkg::*, lane_stream_pkg::*;
#(
  parameter int MAX_NUM_LANES = 4,
  parameter int FIFO_DEPTH    = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  stream_beat_t                         s_dllp_beat_i,
  input  logic                                 s_dllp_valid_i,
  output logic                                 s_dllp_ready_o,
  input  stream_beat_t                         s_os_beat_i,
  input  logic                                 s_os_valid_i,
  output logic                                 s_os_ready_o,
  input  rate_speed_e                          rate_i,
  input  logic [$clog2(MAX_NUM_LANES + 1)-1:0] num_active_lanes_i,
  input  logic                                 lane_reverse_i,
  output pipe_lane_t                           lane_word_o [MAX_NUM_LANES],
  output logic [MAX_NUM_LANES-1:0]             lane_valid_o,
  output logic [5:0]                           pipe_width_o,
  output logic [1:0]                           sync_header_o,
  output logic                                 sync_valid_o
);

  stream_beat_t dllp_head;
  logic         dllp_head_valid;
  logic         dllp_head_ready;
  stream_beat_t os_head;
  logic         os_head_valid;
  logic         os_head_ready;
  logic         block_start;
  logic         is_os;

  beat_fifo #(
    .beat_t     (stream_beat_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dllp_fifo_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_beat_i  (s_dllp_beat_i),
    .wr_valid_i (s_dllp_valid_i),
    .wr_ready_o (s_dllp_ready_o),
    .rd_beat_o  (dllp_head),
    .rd_valid_o (dllp_head_valid),
    .rd_ready_i (dllp_head_ready)
  );

  beat_fifo #(
    .beat_t     (stream_beat_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) os_fifo_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_beat_i  (s_os_beat_i),
    .wr_valid_i (s_os_valid_i),
    .wr_ready_o (s_os_ready_o),
    .rd_beat_o  (os_head),
    .rd_valid_o (os_head_valid),
    .rd_ready_i (os_head_ready)
  );

  lane_management #(
    .MAX_NUM_LANES (MAX_NUM_LANES)
  ) lane_management_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .dllp_beat_i        (dllp_head),
    .dllp_valid_i       (dllp_head_valid),
    .dllp_ready_o       (dllp_head_ready),
    .os_beat_i          (os_head),
    .os_valid_i         (os_head_valid),
    .os_ready_o         (os_head_ready),
    .rate_i             (rate_i),
    .num_active_lanes_i (num_active_lanes_i),
    .lane_reverse_i     (lane_reverse_i),
    .lane_word_o        (lane_word_o),
    .lane_valid_o       (lane_valid_o),
    .pipe_width_o       (pipe_width_o),
    .block_start_o      (block_start),
    .is_os_o            (is_os)
  );

  sync_header_gen #(
    .MAX_NUM_LANES (MAX_NUM_LANES)
  ) sync_header_gen_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rate_i        (rate_i),
    .word_valid_i  (lane_valid_o),
    .block_start_i (block_start),
    .is_os_i       (is_os),
    .sync_header_o (sync_header_o),
    .sync_valid_o  (sync_valid_o)
  );

endmodule

//--- hw/sync_header_gen.sv
`timescale 1ns/100ps

module sync_header_gen
  import pcie_phy_pkg::*;
#(
  parameter int MAX_NUM_LANES = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  rate_speed_e              rate_i,
  input  logic [MAX_NUM_LANES-1:0] word_valid_i,
  input  logic                     block_start_i,
  input  logic                     is_os_i,
  output logic [1:0]               sync_header_o,
  output logic                     sync_valid_o
);

  logic [3:0] sym_cnt_r;
  logic [3:0] last_cnt_c;
  logic       hdr_os_r;
  logic       any_valid_c;
  logic       high_rate_c;

  assign any_valid_c = |word_valid_i;
  assign high_rate_c = (rate_i >= gen3);

  // output cycles per block minus one: 16 symbols over bytes per word
  assign last_cnt_c = 4'(BLOCK_SYMBOLS / (pipe_width_bits[rate_i] / 8) - 1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sym_cnt_r <= '0;
      hdr_os_r  <= 1'b0;
    end else if (any_valid_c) begin
      if (block_start_i) begin
        // header goes out this cycle, next word is the second of the block
        sym_cnt_r <= 4'd1;
        hdr_os_r  <= is_os_i;
      end else if (sym_cnt_r >= last_cnt_c) begin
        sym_cnt_r <= '0;
      end else begin
        sym_cnt_r <= sym_cnt_r + 1'b1;
      end
    end
  end

  assign sync_valid_o  = high_rate_c && any_valid_c && (block_start_i || (sym_cnt_r == '0));
  assign sync_header_o = (block_start_i ? is_os_i : hdr_os_r) ? SYNC_OS : SYNC_DATA;

endmodule

//--- tb/pcie_phy_tx_asserts.sv
`timescale 1ns/100ps

module pcie_phy_tx_asserts
  import lane_stream_pkg::*;
#(
  parameter int MAX_NUM_LANES = 4
) (
  input logic                                 clk_i,
  input logic                                 rst_i,
  input stream_beat_t                         dllp_beat_i,
  input logic                                 dllp_valid_i,
  input logic                                 dllp_ready_i,
  input stream_beat_t                         os_beat_i,
  input logic                                 os_valid_i,
  input logic                                 os_ready_i,
  input logic                                 dllp_grant_i,
  input logic                                 os_grant_i,
  input logic [$clog2(MAX_NUM_LANES + 1)-1:0] num_active_lanes_i,
  input logic [MAX_NUM_LANES-1:0]             lane_valid_i
);

  logic [MAX_NUM_LANES-1:0] idle_lanes_c;

  always_comb begin
    for (int l = 0; l < MAX_NUM_LANES; l++) begin
      idle_lanes_c[l] = (l >= int'(num_active_lanes_i));
    end
  end

  // lane management takes from one source at a time
  one_source_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      !(os_grant_i && dllp_grant_i))
    else $error("both sources ready in the same cycle");

  idle_lanes_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
      (lane_valid_i & idle_lanes_c) == '0)
    else $error("lane_valid set on a lane that is not active");

  // stream inputs at the top
  os_input_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      os_valid_i && !os_ready_i |=> os_valid_i && $stable(os_beat_i))
    else $error("ordered set beat changed before it was taken");

  dllp_input_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      dllp_valid_i && !dllp_ready_i |=> dllp_valid_i && $stable(dllp_beat_i))
    else $error("packet beat changed before it was taken");

endmodule

bind pcie_phy_tx_top pcie_phy_tx_asserts #(
  .MAX_NUM_LANES (MAX_NUM_LANES)
) lane_asserts_inst (
  .clk_i              (clk_i),
  .rst_i              (rst_i),
  .dllp_beat_i        (s_dllp_beat_i),
  .dllp_valid_i       (s_dllp_valid_i),
  .dllp_ready_i       (s_dllp_ready_o),
  .os_beat_i          (s_os_beat_i),
  .os_valid_i         (s_os_valid_i),
  .os_ready_i         (s_os_ready_o),
  .dllp_grant_i       (dllp_head_ready),
  .os_grant_i         (os_head_ready),
  .num_active_lanes_i (num_active_lanes_i),
  .lane_valid_i       (lane_valid_o)
);

//--- tb/pcie_phy_tx_tb.sv
`timescale 1ns/100ps

module pcie_phy_tx_tb
  import pcie_phy_pkg::*, lane_stream_pkg::*;
();

  localparam int NUM_LANES = 4;
  // the random fill test is the longest, well under a thousand cycles
  localparam int TIMEOUT_CYCLES = 4000;

  // one expected output cycle
  typedef struct packed {
    pipe_lane_t [NUM_LANES-1:0] words;
    logic [NUM_LANES-1:0]       valid;
    logic                       sync_v;
    logic [1:0]                 hdr;
    logic                       first;
    logic [5:0]                 width;
  } exp_word_t;

  logic         clk_i = 1'b0;
  logic         rst_i;
  stream_beat_t dllp_beat;
  logic         dllp_valid;
  logic         dllp_ready;
  stream_beat_t os_beat;
  logic         os_valid;
  logic         os_ready;
  rate_speed_e  rate;
  logic [2:0]   num_lanes;
  logic         lane_reverse;
  pipe_lane_t   lane_word [NUM_LANES];
  logic [NUM_LANES-1:0] lane_valid;
  logic [5:0]   pipe_width;
  logic [1:0]   sync_header;
  logic         sync_valid;

  logic [31:0]  lfsr_state = 32'h1467b917;
  exp_word_t    exp_q [$];
  stream_beat_t os_q [$];
  stream_beat_t pkt_q [$];
  rate_speed_e  cur_rate;
  int           cur_lanes;
  bit           cur_rev;
  logic         prev_valid = 1'b0;
  int           errors = 0;
  int           pushed = 0;
  int           checked = 0;
  int           cycles = 0;

  pcie_phy_tx_top #(
    .MAX_NUM_LANES (NUM_LANES),
    .FIFO_DEPTH    (4)
  ) pcie_phy_tx_top_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .s_dllp_beat_i      (dllp_beat),
    .s_dllp_valid_i     (dllp_valid),
    .s_dllp_ready_o     (dllp_ready),
    .s_os_beat_i        (os_beat),
    .s_os_valid_i       (os_valid),
    .s_os_ready_o       (os_ready),
    .rate_i             (rate),
    .num_active_lanes_i (num_lanes),
    .lane_reverse_i     (lane_reverse),
    .lane_word_o        (lane_word),
    .lane_valid_o       (lane_valid),
    .pipe_width_o       (pipe_width),
    .sync_header_o      (sync_header),
    .sync_valid_o       (sync_valid)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d output words never came", cycles, exp_q.size());
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // galois form, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic int width_bytes(input rate_speed_e r);
    case (r)
      gen1: return 1;
      gen2, gen3: return 2;
      default: return 4;
    endcase
  endfunction

  // predicted PIPE words for one collected block
  task automatic expect_block(input stream_beat_t blk[$], input bit os);
    exp_word_t  e;
    int         w;
    int         total;
    int         ncyc;
    int         k;
    logic       mark;
    logic [7:0] pad;
    w     = width_bytes(cur_rate);
    total = 4 * blk.size();
    ncyc  = os ? total / w : (total + cur_lanes * w - 1) / (cur_lanes * w);
    pad   = (cur_rate >= gen3) ? 8'hF7 : 8'h00;
    mark  = 1'b0;
    foreach (blk[i]) begin
      mark = mark | blk[i].lane_num_mark;
    end
    for (int c = 0; c < ncyc; c++) begin
      e        = '0;
      e.first  = (c == 0);
      e.width  = 6'(8 * w);
      e.hdr    = os ? 2'b01 : 2'b10;
      // one header per 16 symbols on a lane
      e.sync_v = (cur_rate >= gen3) && (c % (16 / w) == 0);
      for (int l = 0; l < cur_lanes; l++) begin
        e.valid[l] = 1'b1;
        for (int b = 0; b < w; b++) begin
          k = os ? c * w + b : (c * w + b) * cur_lanes + l;
          if (k < total) begin
            e.words[l].data[8*b +: 8] = blk[k/4].data[8*(k%4) +: 8];
            e.words[l].datak[b]       = blk[k/4].kchar[k%4];
          end else begin
            e.words[l].data[8*b +: 8] = pad;
          end
          if (os && mark && k == 2) begin
            e.words[l].data[8*b +: 8] = cur_rev ? 8'(cur_lanes - 1 - l) : 8'(l);
            e.words[l].datak[b]       = 1'b0;
          end
        end
      end
      exp_q.push_back(e);
      pushed++;
    end
  endtask

  // blocks end on last or after 16 beats
  task automatic expect_stream(input stream_beat_t q[$], input bit os);
    stream_beat_t blk [$];
    foreach (q[i]) begin
      blk.push_back(q[i]);
      if (q[i].last || blk.size() == 16) begin
        expect_block(blk, os);
        blk.delete();
      end
    end
  endtask

  task automatic build_packet(input int n);
    stream_beat_t b;
    for (int i = 0; i < n; i++) begin
      b       = '0;
      b.data  = rand_bits(32);
      b.keep  = 4'hF;
      b.kchar = ((i == 0) ? 4'b0001 : 4'b0000) | ((i == n - 1) ? 4'b1000 : 4'b0000);
      b.last  = (i == n - 1);
      pkt_q.push_back(b);
    end
  endtask

  task automatic build_os(input int n, input bit mark);
    stream_beat_t b;
    for (int i = 0; i < n; i++) begin
      b               = '0;
      b.data          = rand_bits(32);
      b.keep          = 4'hF;
      b.kchar         = (i == 0) ? 4'b0001 : 4'b0000;
      b.last          = (i == n - 1);
      b.lane_num_mark = mark && (i == 0);
      os_q.push_back(b);
    end
  endtask

  task automatic drive_beat(input bit os, input stream_beat_t beat, input logic valid);
    if (os) begin
      os_beat  = beat;
      os_valid = valid;
    end else begin
      dllp_beat  = beat;
      dllp_valid = valid;
    end
  endtask

  // valid is raised before ready is looked at and held until taken
  task automatic send_stream(input bit os, input stream_beat_t beats[$], input bit gaps);
    int gap;
    bit taken;
    foreach (beats[i]) begin
      gap = gaps ? int'(rand_bits(2)) : 0;
      repeat (gap) begin
        drive_beat(os, '0, 1'b0);
        @(posedge clk_i);
        #1;
      end
      drive_beat(os, beats[i], 1'b1);
      // ready seen mid-cycle means the beat goes on the next rising edge
      do begin
        @(negedge clk_i);
        taken = os ? os_ready : dllp_ready;
        @(posedge clk_i);
      end while (!taken);
      #1;
    end
    drive_beat(os, '0, 1'b0);
  endtask

  task automatic configure(input rate_speed_e r, input int lanes, input bit rev);
    cur_rate     = r;
    cur_lanes    = lanes;
    cur_rev      = rev;
    rate         = r;
    num_lanes    = 3'(lanes);
    lane_reverse = rev;
    @(posedge clk_i);
    #1;
  endtask

  // queued ordered sets go before queued packets
  task automatic run_queued(input bit parallel, input bit gaps);
    expect_stream(os_q, 1'b1);
    expect_stream(pkt_q, 1'b0);
    if (parallel) begin
      fork
        send_stream(1'b1, os_q, gaps);
        send_stream(1'b0, pkt_q, gaps);
      join
    end else begin
      send_stream(1'b1, os_q, gaps);
      send_stream(1'b0, pkt_q, gaps);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    #1;
    os_q.delete();
    pkt_q.delete();
  endtask

  always @(negedge clk_i) begin
    exp_word_t e;
    if (!rst_i) begin
      if (lane_valid != '0) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output word on lanes %b at %0t with none expected", lane_valid, $time);
        end else begin
          e = exp_q.pop_front();
          checked++;
          if (e.first == prev_valid) begin
            errors++;
            $display("[ERROR] %0t: block boundary does not match lane_valid", $time);
          end
          if (lane_valid != e.valid || pipe_width != e.width) begin
            errors++;
            $display("[ERROR] %0t: lane_valid %b width %0d expected %b width %0d",
                     $time, lane_valid, pipe_width, e.valid, e.width);
          end
          for (int l = 0; l < NUM_LANES; l++) begin
            if (lane_word[l] != e.words[l]) begin
              errors++;
              $display("[ERROR] %0t: lane %0d word %h expected %h",
                       $time, l, lane_word[l], e.words[l]);
            end
          end
          if (sync_valid != e.sync_v || (e.sync_v && sync_header != e.hdr)) begin
            errors++;
            $display("[ERROR] %0t: sync %b/%b expected %b/%b",
                     $time, sync_valid, sync_header, e.sync_v, e.hdr);
          end
        end
      end else if (sync_valid) begin
        errors++;
        $display("[ERROR] %0t: sync header without an output word", $time);
      end
      prev_valid = (lane_valid != '0);
    end
  end

  task automatic reset_values();
    int waited;
    repeat (3) @(negedge clk_i);
    if (dllp_ready || os_ready || lane_valid != '0 || sync_valid || pipe_width != 6'd8) begin
      errors++;
      $display("[ERROR] %0t: outputs not at their reset values", $time);
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_i  = 1'b0;
    waited = 0;
    while (!(dllp_ready && os_ready) && waited < 4) begin
      @(posedge clk_i);
      waited++;
    end
    #1;
    if (!(dllp_ready && os_ready)) begin
      errors++;
      $display("ready outputs did not rise after reset was released");
    end
  endtask

  task automatic striped_packets();
    configure(gen1, 4, 1'b0);
    build_packet(6);
    run_queued(1'b0, 1'b0);
    configure(gen2, 3, 1'b0);
    build_packet(6);
    build_packet(5);
    run_queued(1'b0, 1'b0);
  endtask

  task automatic marked_os_gen3();
    configure(gen3, 4, 1'b0);
    build_os(4, 1'b1);
    build_packet(5);
    run_queued(1'b0, 1'b0);
  endtask

  task automatic reversed_lanes_gen5();
    configure(gen5, 2, 1'b1);
    build_os(8, 1'b1);
    build_packet(16);
    run_queued(1'b0, 1'b0);
  endtask

  task automatic os_over_packets();
    configure(gen2, 4, 1'b0);
    build_os(4, 1'b0);
    build_packet(5);
    build_packet(3);
    run_queued(1'b1, 1'b0);
  endtask

  task automatic random_gap_fill();
    configure(gen4, 3, 1'b0);
    for (int p = 0; p < 6; p++) begin
      build_packet(8 + int'(rand_bits(5)));
    end
    run_queued(1'b0, 1'b1);
  endtask

  initial begin
    rst_i        = 1'b1;
    dllp_beat    = '0;
    dllp_valid   = 1'b0;
    os_beat      = '0;
    os_valid     = 1'b0;
    rate         = gen1;
    num_lanes    = 3'd1;
    lane_reverse = 1'b0;
    reset_values();
    striped_packets();
    marked_os_gen3();
    reversed_lanes_gen5();
    os_over_packets();
    random_gap_fill();
    $display("errors: %0d, words checked: %0d of %0d", errors, checked, pushed);
    if (errors == 0 && checked == pushed) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
